// ==== common/acq_event_if.sv ====
/*
  per-sample events from the sequencer to the result block
  done pulse, current index, first flag and switch state
*/

interface acq_event_if;

  // one cycle pulse at the end of each measurement
  logic       sample_done;
  // entry currently being worked on
  logic [2:0] sample_idx;
  // set for the first sample after reset
  logic       first;
  // current switch outputs, for the monitor bus
  logic [3:0] azmux;
  logic [1:0] pc_sw;

  modport src (
    output sample_done, output sample_idx, output first,
    output azmux, output pc_sw
  );

  modport dst (
    input sample_done, input sample_idx, input first,
    input azmux, input pc_sw
  );

endinterface

// ==== common/acq_pkg.sv ====
/*
  shared definitions for the acquisition sequencer
  sequencer states, register addresses, sequence entry type,
  auto-zero mux codes and index constants
*/

package acq_pkg;

  ////////////////////////////////////////
  // sequencer states

  // one state per switch step, each step followed by its pause
  typedef enum logic [2:0] {
    IDLE,
    BOOT,
    BOOT_WAIT,
    AZMUX_SET,
    AZMUX_WAIT,
    PC_SET,
    PC_WAIT,
    MEASURE
  } acq_state_e;

  ////////////////////////////////////////
  // mcu register addresses, used as write opcodes

  // anything not listed here is ignored by the decoder
  typedef enum logic [3:0] {
    REG_PRECHARGE = 4'h0,
    REG_SEQ_N     = 4'h1,
    REG_SEQ0      = 4'h2,
    REG_SEQ1      = 4'h3,
    REG_SEQ2      = 4'h4,
    REG_SEQ3      = 4'h5
  } reg_addr_e;

  // one entry of the sequence, { pc switch value, azmux code }
  typedef struct packed {
    logic [1:0] pc_sw;
    logic [3:0] azmux;
  } seq_entry_t;

  // azmux codes, top bit is the mux enable
  localparam logic [3:0] AZMUX_S1 = 4'b1000;
  localparam logic [3:0] AZMUX_S3 = 4'b1010;
  localparam logic [3:0] AZMUX_S7 = 4'b1110;
  localparam logic [3:0] AZMUX_S8 = 4'b1111;

  // precharge switches parked on boot, protects the signal
  localparam logic [1:0] PC_BOOT = 2'b00;

  localparam int SEQ_MAX = 4;

  // all ones, so never confused with the first entry
  localparam logic [2:0] IDX_NONE = 3'b111;

endpackage

// ==== common/seq_cfg_if.sv ====
/*
  sequence configuration bundle
  precharge pause, sequence length and the sequence entries
*/

interface seq_cfg_if
  import acq_pkg::*;
#(
  parameter int CLK_COUNT_W = 24
);

  // pause length in clocks, shared by all three pauses
  logic [CLK_COUNT_W-1:0]       clk_count_precharge;
  // number of active entries, 1 to SEQ_MAX
  logic [2:0]                   seq_n;
  // entries indexed by sample_idx
  seq_entry_t [SEQ_MAX-1:0]     seq_entries;

  // register decode holds the values
  modport decode (output clk_count_precharge, output seq_n, output seq_entries);

  // sequencer samples them as levels
  modport seq (input clk_count_precharge, input seq_n, input seq_entries);

endinterface

// ==== hw/acq_reg_decode.sv ====
/*
  mcu register write decode
  holds the precharge pause, sequence length and sequence entries
  sequence length is clamped into 1 to SEQ_MAX
*/

module acq_reg_decode
  import acq_pkg::*;
#(
  parameter int CLK_COUNT_W = 24
)
(
  input  logic        clk,
  input  logic        reset_n,

  // mcu write port
  input  logic        reg_wr_i,
  input  logic [3:0]  reg_addr_i,
  input  logic [23:0] reg_wdata_i,

  seq_cfg_if.decode   cfg
);

  reg_addr_e  addr;
  logic [2:0] seq_n_clamped;
  seq_entry_t wr_entry;

  // address doubles as the write opcode
  assign addr = reg_addr_e'(reg_addr_i);

  // entry fields sit in the low 6 bits of the write data
  assign wr_entry = seq_entry_t'(reg_wdata_i[5:0]);

  // never hand the sequencer an empty or oversize sequence
  // compare on the full write word so high garbage bits clamp too
  always_comb
  begin
    if (reg_wdata_i == 24'd0)
      seq_n_clamped = 3'd1;
    else if (reg_wdata_i > 24'(SEQ_MAX))
      seq_n_clamped = 3'(SEQ_MAX);
    else
      seq_n_clamped = reg_wdata_i[2:0];
  end

  ////////////////////////////////////////
  // held configuration

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      // single entry of all zeros, no pause
      cfg.clk_count_precharge <= '0;
      cfg.seq_n               <= 3'd1;
      cfg.seq_entries         <= '0;
    end
    else if (reg_wr_i)
    begin
      case (addr)
        REG_PRECHARGE: cfg.clk_count_precharge <= CLK_COUNT_W'(reg_wdata_i);
        REG_SEQ_N:     cfg.seq_n               <= seq_n_clamped;
        REG_SEQ0:      cfg.seq_entries[0]      <= wr_entry;
        REG_SEQ1:      cfg.seq_entries[1]      <= wr_entry;
        REG_SEQ2:      cfg.seq_entries[2]      <= wr_entry;
        REG_SEQ3:      cfg.seq_entries[3]      <= wr_entry;
        // unknown addresses are dropped
        default:
        begin
        end
      endcase
    end
  end

  // sequence length stays legal across every write
  a_seq_n_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    (cfg.seq_n >= 3'd1) && (cfg.seq_n <= 3'(SEQ_MAX))
  ) else $error("seq_n out of range: %0d", cfg.seq_n);

endmodule

// ==== hw/acq_status.sv ====
/*
  result latch and indicators
  status byte with first flag, last index and sample count,
  one-hot leds and the monitor bus
*/

module acq_status
  import acq_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,

  acq_event_if.dst    ev,

  // raw adc lines, only mirrored on the monitor bus
  input  logic        adc_measure_valid_i,
  input  logic        adc_reset_n_i,

  output logic        first_last_o,
  output logic [2:0]  sample_idx_last_o,
  output logic [7:0]  status_o,
  output logic [3:0]  leds_o,
  output logic [7:0]  monitor_o
);

  logic [3:0] sample_count;
  // index and first flag one cycle back, still those of the finished sample
  logic [2:0] idx_d;
  logic       first_d;

  // sequencer steps index and first together with the done pulse
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      idx_d   <= '0;
      first_d <= 1'b0;
    end
    else
    begin
      idx_d   <= ev.sample_idx;
      first_d <= ev.first;
    end
  end

  ////////////////////////////////////////
  // lagged results

  // latched on done, stable for the mcu during the next measurement
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      first_last_o      <= 1'b0;
      sample_idx_last_o <= IDX_NONE;
      sample_count      <= '0;
    end
    else if (ev.sample_done)
    begin
      first_last_o      <= first_d;
      sample_idx_last_o <= idx_d;
      // wraps at 16, the mcu only needs to see it move
      sample_count      <= sample_count + 4'd1;
    end
  end

  // { first, last index, count }
  assign status_o = {first_last_o, sample_idx_last_o, sample_count};

  // one lit led per entry in progress
  assign leds_o = 4'(4'b0001 << ev.sample_idx);

  ////////////////////////////////////////
  // monitor bus for the scope

  assign monitor_o[0]   = (ev.azmux == AZMUX_S3);
  assign monitor_o[1]   = (ev.azmux == AZMUX_S7);
  assign monitor_o[2]   = (ev.azmux == AZMUX_S1);
  assign monitor_o[3]   = (ev.azmux == AZMUX_S8);
  assign monitor_o[5:4] = ev.pc_sw;
  assign monitor_o[6]   = adc_reset_n_i;
  assign monitor_o[7]   = adc_measure_valid_i;

  // sequencer has to pass through the switch steps between samples
  a_done_spacing: assert property (
    @(posedge clk) disable iff (!reset_n)
    ev.sample_done |=> !ev.sample_done
  ) else $error("sample_done on consecutive cycles");

endmodule

// ==== hw/acq_top.sv ====
/*
  acquisition front end top level
  register decode, sequencer and status block
*/

module acq_top #(
  parameter int CLK_COUNT_W = 24
)
(
  input  logic        clk,
  input  logic        reset_n,

  // mcu register writes
  input  logic        reg_wr_i,
  input  logic [3:0]  reg_addr_i,
  input  logic [23:0] reg_wdata_i,

  // adc
  input  logic        adc_measure_valid_i,
  output logic        adc_reset_n_o,

  // switches
  output logic [1:0]  pc_sw_o,
  output logic [3:0]  azmux_o,

  // results and indicators
  output logic        first_last_o,
  output logic [2:0]  sample_idx_last_o,
  output logic [7:0]  status_o,
  output logic [3:0]  leds_o,
  output logic [7:0]  monitor_o
);

  seq_cfg_if #(.CLK_COUNT_W(CLK_COUNT_W)) cfg_if ();
  acq_event_if                            ev_if ();

  acq_reg_decode #(.CLK_COUNT_W(CLK_COUNT_W)) u_reg_decode (
    .clk          (clk),
    .reset_n      (reset_n),
    .reg_wr_i     (reg_wr_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .cfg          (cfg_if.decode)
  );

  sequence_acquisition #(.CLK_COUNT_W(CLK_COUNT_W)) u_sequencer (
    .clk                  (clk),
    .reset_n              (reset_n),
    .cfg                  (cfg_if.seq),
    .adc_measure_valid_i  (adc_measure_valid_i),
    .adc_reset_n_o        (adc_reset_n_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .ev                   (ev_if.src)
  );

  // status also watches the raw adc lines
  acq_status u_status (
    .clk                  (clk),
    .reset_n              (reset_n),
    .ev                   (ev_if.dst),
    .adc_measure_valid_i  (adc_measure_valid_i),
    .adc_reset_n_i        (adc_reset_n_o),
    .first_last_o         (first_last_o),
    .sample_idx_last_o    (sample_idx_last_o),
    .status_o             (status_o),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the acquisition testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module acq_tb -f tb.f \
  && ./obj_dir/Vacq_tb > sim.log 2>&1 \
  || { echo "build or simulation error"; cat sim.log 2>/dev/null; exit 1; }
grep -q "^Everything OK$" sim.log \
  && echo "simulation passed" \
  || { cat sim.log; exit 1; }

// ==== sequencer/sequence_acquisition.sv ====
/*
  acquisition sequencer FSM
  parks precharge on boot, sets azmux, sets precharge switches,
  pausing after each step, then releases the adc and waits for
  measure valid before stepping to the next sequence entry
*/

module sequence_acquisition
  import acq_pkg::*;
#(
  parameter int CLK_COUNT_W = 24
)
(
  input  logic        clk,
  input  logic        reset_n,

  seq_cfg_if.seq      cfg,

  // adc control
  input  logic        adc_measure_valid_i,
  output logic        adc_reset_n_o,

  // switch drive
  output logic [1:0]  pc_sw_o,
  output logic [3:0]  azmux_o,

  acq_event_if.src    ev
);

  acq_state_e             state;

  // free running, reloaded at each switch step
  logic [CLK_COUNT_W-1:0] count_down;

  logic [2:0]             sample_idx;
  logic                   first;
  logic                   sample_done;

  // entry selected by the current index
  seq_entry_t             cur_entry;

  // index is always below SEQ_MAX so the low 2 bits select
  assign cur_entry = cfg.seq_entries[sample_idx[1:0]];

  // per-sample state to the result block
  assign ev.sample_done = sample_done;
  assign ev.sample_idx  = sample_idx;
  assign ev.first       = first;
  assign ev.azmux       = azmux_o;
  assign ev.pc_sw       = pc_sw_o;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state         <= IDLE;
      count_down    <= '0;
      sample_idx    <= '0;
      first         <= 1'b0;
      sample_done   <= 1'b0;
      adc_reset_n_o <= 1'b0;
      pc_sw_o       <= PC_BOOT;
      azmux_o       <= '0;
    end
    else
    begin
      // pause counter always runs down
      count_down  <= count_down - 1'b1;
      // done is a single cycle pulse
      sample_done <= 1'b0;

      case (state)

        ////////////////////////////////////////
        // start of run

        IDLE:
        begin
          state         <= BOOT;
          // adc held in reset until the first measurement
          adc_reset_n_o <= 1'b0;
          sample_idx    <= '0;
          first         <= 1'b1;
          pc_sw_o       <= PC_BOOT;
          // give the mux a defined input, the first entry
          azmux_o       <= cfg.seq_entries[0].azmux;
        end

        // park precharge on boot before touching the mux
        BOOT:
        begin
          state      <= BOOT_WAIT;
          count_down <= cfg.clk_count_precharge;
          pc_sw_o    <= PC_BOOT;
        end

        BOOT_WAIT:
        begin
          if (count_down == '0)
            state <= AZMUX_SET;
        end

        ////////////////////////////////////////
        // switch the auto-zero mux

        // charge injection of the mux lands on the boot node
        AZMUX_SET:
        begin
          state      <= AZMUX_WAIT;
          count_down <= cfg.clk_count_precharge;
          azmux_o    <= cur_entry.azmux;
        end

        AZMUX_WAIT:
        begin
          if (count_down == '0)
            state <= PC_SET;
        end

        ////////////////////////////////////////
        // move precharge onto the signal

        // a zero entry leaves the switches on boot
        // the pause still runs so timing stays the same
        PC_SET:
        begin
          state      <= PC_WAIT;
          count_down <= cfg.clk_count_precharge;
          pc_sw_o    <= cur_entry.pc_sw;
        end

        PC_WAIT:
        begin
          if (count_down == '0)
          begin
            state         <= MEASURE;
            // adc start
            adc_reset_n_o <= 1'b1;
          end
        end

        // wait for the adc, no timeout here
        MEASURE:
        begin
          if (adc_measure_valid_i)
          begin
            state         <= BOOT;
            sample_done   <= 1'b1;
            first         <= 1'b0;
            adc_reset_n_o <= 1'b0;
            // >= so a shortened sequence wraps at once
            if (sample_idx >= cfg.seq_n - 3'd1)
              sample_idx <= '0;
            else
              sample_idx <= sample_idx + 3'd1;
          end
        end

        default:
        begin
          state <= IDLE;
        end

      endcase
    end
  end

  // adc only runs during the measure phase
  a_adc_in_measure: assert property (
    @(posedge clk) disable iff (!reset_n)
    adc_reset_n_o |-> (state == MEASURE)
  ) else $error("adc released outside MEASURE, state %0d", state);

  a_idx_range: assert property (
    @(posedge clk) disable iff (!reset_n)
    sample_idx < 3'(SEQ_MAX)
  ) else $error("sample_idx out of range: %0d", sample_idx);

endmodule

// ==== tb.f ====
common/acq_pkg.sv
common/seq_cfg_if.sv
common/acq_event_if.sv
hw/acq_reg_decode.sv
sequencer/sequence_acquisition.sv
hw/acq_status.sv
hw/acq_top.sv
tb/tb_clock.sv
tb/acq_tb.sv

// ==== tb/acq_tb.sv ====
/*
  testbench for the acquisition front end
  register setup, adc model with lfsr delays, scoreboard,
  concurrent checks and the closing report
*/

module acq_tb
  import acq_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // 14 samples of about 30 cycles each plus setup, far below this
  localparam int TIMEOUT_CYCLES = 8000;
  localparam int SAMPLES_LONG   = 8;
  localparam int SAMPLES_TOTAL  = 14;

  logic        clk;
  logic        reset_n;
  logic        reg_wr_i;
  logic [3:0]  reg_addr_i;
  logic [23:0] reg_wdata_i;
  logic        adc_measure_valid_i;
  logic        adc_reset_n_o;
  logic [1:0]  pc_sw_o;
  logic [3:0]  azmux_o;
  logic        first_last_o;
  logic [2:0]  sample_idx_last_o;
  logic [7:0]  status_o;
  logic [3:0]  leds_o;
  logic [7:0]  monitor_o;

  // scoreboard state
  seq_entry_t  entries [SEQ_MAX];
  logic [2:0]  tb_seq_n;
  logic [2:0]  cur_idx;
  logic [2:0]  meas_idx;
  logic        meas_first;
  logic [2:0]  exp_last_idx;
  logic        seq_first;
  logic        exp_first_last;
  logic        valid_d;
  int          done_count  = 0;
  int          error_count = 0;
  int          cycle_count = 0;
  logic [7:0]  lfsr_state  = 8'd69;

  tb_clock u_clock (.clk_o(clk));

  acq_top #(.CLK_COUNT_W(24)) i_acq_top (
    .clk                  (clk),
    .reset_n              (reset_n),
    .reg_wr_i             (reg_wr_i),
    .reg_addr_i           (reg_addr_i),
    .reg_wdata_i          (reg_wdata_i),
    .adc_measure_valid_i  (adc_measure_valid_i),
    .adc_reset_n_o        (adc_reset_n_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .first_last_o         (first_last_o),
    .sample_idx_last_o    (sample_idx_last_o),
    .status_o             (status_o),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o)
  );

  ////////////////////////////////////////
  // helpers

  // taps 8 6 5 4, shifts right, new bit enters at the top
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[0] ^ s[2] ^ s[3] ^ s[4], s[7:1]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int n, output int unsigned value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      value      = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // next entry, back to the first once no active entry is left after this one
  function automatic logic [2:0] wrap_index(input logic [2:0] idx, input logic [2:0] n);
    if (int'(idx) + 1 < int'(n))
      return idx + 3'd1;
    else
      return 3'd0;
  endfunction

  // monitor bits 3..0 for a given mux code
  function automatic logic [3:0] mux_flags(input logic [3:0] az);
    return {az == AZMUX_S8, az == AZMUX_S1, az == AZMUX_S7, az == AZMUX_S3};
  endfunction

  task automatic report_mismatch(input string sig, input int expected, input int actual);
    error_count++;
    $display("FAILED %0d ns: %s expected %0h, got %0h", $time, sig, expected, actual);
  endtask

  // one cycle write strobe, called right after a rising edge
  task automatic write_reg(input reg_addr_e addr, input logic [23:0] data);
    reg_wr_i    <= 1'b1;
    reg_addr_i  <= addr;
    reg_wdata_i <= data;
    @(posedge clk);
    reg_wr_i    <= 1'b0;
  endtask

  ////////////////////////////////////////
  // adc model

  // answers each release with a one cycle valid after 0 to 7 clocks
  initial
  begin
    int unsigned delay;
    forever
    begin
      @(posedge clk);
      if (adc_reset_n_o)
      begin
        draw_bits(3, delay);
        repeat (delay) @(posedge clk);
        adc_measure_valid_i <= 1'b1;
        @(posedge clk);
        adc_measure_valid_i <= 1'b0;
        // sequencer pulls the adc back into reset
        while (adc_reset_n_o) @(posedge clk);
      end
    end
  end

  // scoreboard, index steps on valid, status one cycle later
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      cur_idx        <= 3'd0;
      seq_first      <= 1'b1;
      valid_d        <= 1'b0;
      meas_idx       <= 3'd0;
      meas_first     <= 1'b0;
      exp_last_idx   <= IDX_NONE;
      exp_first_last <= 1'b0;
      done_count     <= 0;
    end
    else
    begin
      valid_d <= adc_measure_valid_i;
      if (adc_measure_valid_i)
      begin
        // the entry that just finished, before stepping on
        meas_idx   <= cur_idx;
        meas_first <= seq_first;
        seq_first  <= 1'b0;
        cur_idx    <= wrap_index(cur_idx, tb_seq_n);
      end
      // status shows the finished entry one cycle after done
      if (valid_d)
      begin
        exp_last_idx   <= meas_idx;
        exp_first_last <= meas_first;
        done_count     <= done_count + 1;
      end
    end
  end

  ////////////////////////////////////////
  // checks

  a_pc_parked: assert property (
    @(posedge clk) $rose(reset_n) |-> pc_sw_o == PC_BOOT
  ) else report_mismatch("pc_sw_o", int'(PC_BOOT), int'($sampled(pc_sw_o)));

  // adc stays in reset while precharge sits on boot
  a_adc_parked: assert property (
    @(posedge clk) disable iff (!reset_n)
    (pc_sw_o == PC_BOOT) |-> !adc_reset_n_o
  ) else report_mismatch("adc_reset_n_o", 0, 1);

  // the cycle before the switches leave boot the mux already holds the entry
  a_mux_first: assert property (
    @(posedge clk) disable iff (!reset_n)
    (pc_sw_o != $past(pc_sw_o) && pc_sw_o != PC_BOOT)
      |-> $past(azmux_o) == entries[cur_idx[1:0]].azmux
  ) else report_mismatch("azmux_o", int'(entries[$sampled(cur_idx[1:0])].azmux),
                         int'($past(azmux_o)));

  a_mux_value: assert property (
    @(posedge clk) disable iff (!reset_n)
    (pc_sw_o != PC_BOOT && !valid_d) |-> azmux_o == entries[cur_idx[1:0]].azmux
  ) else report_mismatch("azmux_o", int'(entries[$sampled(cur_idx[1:0])].azmux),
                         int'($sampled(azmux_o)));

  a_pc_value: assert property (
    @(posedge clk) disable iff (!reset_n)
    (pc_sw_o != PC_BOOT && !valid_d) |-> pc_sw_o == entries[cur_idx[1:0]].pc_sw
  ) else report_mismatch("pc_sw_o", int'(entries[$sampled(cur_idx[1:0])].pc_sw),
                         int'($sampled(pc_sw_o)));

  a_idx_last: assert property (
    @(posedge clk) disable iff (!reset_n) sample_idx_last_o == exp_last_idx
  ) else report_mismatch("sample_idx_last_o", int'($sampled(exp_last_idx)),
                         int'($sampled(sample_idx_last_o)));

  a_status_idx: assert property (
    @(posedge clk) disable iff (!reset_n) status_o[6:4] == exp_last_idx
  ) else report_mismatch("status_o[6:4]", int'($sampled(exp_last_idx)),
                         int'($sampled(status_o[6:4])));

  a_status_count: assert property (
    @(posedge clk) disable iff (!reset_n) status_o[3:0] == 4'(done_count)
  ) else report_mismatch("status_o[3:0]", $sampled(done_count) % 16,
                         int'($sampled(status_o[3:0])));

  a_first_last: assert property (
    @(posedge clk) disable iff (!reset_n)
    (first_last_o == exp_first_last) && (status_o[7] == exp_first_last)
  ) else report_mismatch("first_last_o", int'($sampled(exp_first_last)),
                         int'($sampled(first_last_o)));

  // exactly one led lit, the one of the entry in progress
  a_leds: assert property (
    @(posedge clk) disable iff (!reset_n) $onehot(leds_o) && leds_o[cur_idx[1:0]]
  ) else report_mismatch("leds_o", 1 << $sampled(cur_idx),
                         int'($sampled(leds_o)));

  a_monitor: assert property (
    @(posedge clk) disable iff (!reset_n)
    monitor_o == {adc_measure_valid_i, adc_reset_n_o, pc_sw_o, mux_flags(azmux_o)}
  ) else report_mismatch("monitor_o",
                         int'({$sampled(adc_measure_valid_i), $sampled(adc_reset_n_o),
                               $sampled(pc_sw_o), mux_flags($sampled(azmux_o))}),
                         int'($sampled(monitor_o)));

  ////////////////////////////////////////
  // stimulus and report

  initial
  begin
    reset_n             = 1'b0;
    reg_wr_i            = 1'b0;
    reg_addr_i          = '0;
    reg_wdata_i         = '0;
    adc_measure_valid_i = 1'b0;
    tb_seq_n            = 3'd1;
    // one entry per watched mux code, switches never on boot
    entries[0] = '{pc_sw: 2'b01, azmux: AZMUX_S3};
    entries[1] = '{pc_sw: 2'b10, azmux: AZMUX_S7};
    entries[2] = '{pc_sw: 2'b11, azmux: AZMUX_S1};
    entries[3] = '{pc_sw: 2'b01, azmux: AZMUX_S8};

    repeat (5) @(posedge clk);
    reset_n <= 1'b1;
    // writes land before the first mux step reads entry 0
    write_reg(REG_PRECHARGE, 24'd3);
    write_reg(REG_SEQ0, 24'(entries[0]));
    write_reg(REG_SEQ1, 24'(entries[1]));
    write_reg(REG_SEQ2, 24'(entries[2]));
    write_reg(REG_SEQ3, 24'(entries[3]));
    write_reg(REG_SEQ_N, 24'd3);
    tb_seq_n <= 3'd3;

    // shorten the sequence while entry 2 is in progress
    // a zero length is clamped to a single entry
    wait (done_count == SAMPLES_LONG);
    @(posedge clk);
    write_reg(REG_SEQ_N, 24'd0);
    tb_seq_n <= 3'd1;

    wait (done_count == SAMPLES_TOTAL);
    repeat (4) @(posedge clk);
    $display("samples %0d, errors %0d", done_count, error_count);
    if (error_count == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout after %0d cycles, the sequencer stopped producing samples",
               cycle_count);
      $display("samples %0d, errors %0d", done_count, error_count);
      $display("Something failed");
      $finish;
    end
  end

endmodule

// ==== tb/tb_clock.sv ====
/*
  testbench clock source
  free running, 20 ns period
*/

module tb_clock
#(
  parameter int HALF_PERIOD_NS = 10
)
(
  output logic clk_o
);

  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    forever
    begin
      #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end
  end

endmodule
